// ==== design/rt_pkg.sv ====
`default_nettype none

package rt_pkg;

  localparam int EXP_BIAS = 127;
  localparam int MANT_W = 24;           // hidden bit included
  localparam int ITER_STEPS = 26;       // 24 mantissa + guard + one spare
  localparam logic [31:0] QNAN_WORD = 32'h7fc0_0000;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp32_fields_s;

  typedef union packed {
    logic [31:0]  raw;
    fp32_fields_s f;
  } fp32_word_u;

  typedef enum logic {
    op_div,
    op_sqrt
  } rt_op_e;

  // result class, decided before the iteration starts
  typedef enum logic [1:0] {
    cls_num,
    cls_zero,
    cls_inf,
    cls_nan
  } rt_class_e;

  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_s;

endpackage

`default_nettype wire

// ==== design/rt_job_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rt_job_if #(
  parameter int TAG_W = 4
);
  import rt_pkg::*;

  logic [1:0]          start;   // one bit per engine
  rt_op_e              op;
  logic                sign;
  logic signed [9:0]   exp_q;   // biased, before normalize
  logic [MANT_W:0]     mant_a;  // one extra bit for odd sqrt
  logic [MANT_W-1:0]   mant_b;
  rt_class_e           cls;
  fp_flags_s           flags_pre;
  logic [TAG_W-1:0]    tag;
  wire  [1:0]          idle;    // each engine drives its own bit

  modport front (output start, op, sign, exp_q, mant_a, mant_b, cls, flags_pre, tag,
                 input idle);

  modport engine (input start, op, sign, exp_q, mant_a, mant_b, cls, flags_pre, tag,
                  output idle);

endinterface

`default_nettype wire

// ==== design/rt_res_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rt_res_if #(
  parameter int TAG_W = 4
);
  import rt_pkg::*;

  logic                  done;    // level, held until take
  logic                  sign;
  logic signed [9:0]     exp_q;
  logic [ITER_STEPS-1:0] quot;    // msb has weight 2^0
  logic                  sticky;
  rt_class_e             cls;
  fp_flags_s             flags_pre;
  logic [TAG_W-1:0]      tag;
  logic                  take;

  modport source (output done, sign, exp_q, quot, sticky, cls, flags_pre, tag,
                  input take);

  modport sink (input done, sign, exp_q, quot, sticky, cls, flags_pre, tag,
                output take);

endinterface

`default_nettype wire

// ==== design/rt_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module rt_unpack #(
  parameter int TAG_W = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_en,
  input  rt_pkg::rt_op_e    in_op,
  input  logic [31:0]       in_a,
  input  logic [31:0]       in_b,
  input  logic [TAG_W-1:0]  in_tag,
  output logic              busy,
  rt_job_if.front           job
);
  import rt_pkg::*;

  fp32_word_u        wa;
  fp32_word_u        wb;
  rt_class_e         ca;
  rt_class_e         cb;
  logic              snan_a;
  logic              snan_b;
  logic signed [9:0] ea;
  logic signed [9:0] eb;
  logic signed [9:0] e_unb;
  rt_class_e         cls_d;
  fp_flags_s         flg_d;
  logic              sign_d;
  logic signed [9:0] exp_d;
  logic [MANT_W:0]   ma_d;
  logic [MANT_W-1:0] mb_d;

  logic              job_v;
  rt_op_e            op_r;
  logic              sign_r;
  logic signed [9:0] exp_r;
  logic [MANT_W:0]   ma_r;
  logic [MANT_W-1:0] mb_r;
  rt_class_e         cls_r;
  fp_flags_s         flg_r;
  logic [TAG_W-1:0]  tag_r;

  // subnormals count as zero
  function automatic rt_class_e classify(fp32_word_u w);
    if (w.f.exp == 8'h00) return cls_zero;
    if (w.f.exp != 8'hff) return cls_num;
    return (w.f.frac == '0) ? cls_inf : cls_nan;
  endfunction

  assign wa.raw = in_a;
  assign wb.raw = in_b;
  assign ca = classify(wa);
  assign cb = classify(wb);
  assign snan_a = (ca == cls_nan) && !wa.f.frac[22];
  assign snan_b = (cb == cls_nan) && !wb.f.frac[22];

  assign ea = $signed({2'b00, wa.f.exp});
  assign eb = $signed({2'b00, wb.f.exp});
  assign e_unb = ea - 10'(EXP_BIAS);

  assign exp_d = (in_op == op_sqrt) ? (e_unb >>> 1) + 10'(EXP_BIAS)
                                    : ea - eb + 10'(EXP_BIAS);
  // odd exponent: radicand x2 so the exponent halves exactly
  assign ma_d = (in_op == op_sqrt && e_unb[0]) ? {1'b1, wa.f.frac, 1'b0}
                                               : {2'b01, wa.f.frac};
  assign mb_d = {1'b1, wb.f.frac};

  always_comb begin
    cls_d = cls_num;
    flg_d = '0;
    sign_d = wa.f.sign ^ wb.f.sign;
    if (in_op == op_sqrt) begin
      sign_d = wa.f.sign;
      if (ca == cls_nan) begin
        cls_d = cls_nan;
        flg_d.invalid = snan_a;
      end else if (ca == cls_zero) begin
        cls_d = cls_zero;                 // sqrt(-0) stays -0
      end else if (wa.f.sign) begin
        cls_d = cls_nan;
        flg_d.invalid = 1'b1;
      end else if (ca == cls_inf) begin
        cls_d = cls_inf;
      end
    end else begin
      if (ca == cls_nan || cb == cls_nan) begin
        cls_d = cls_nan;
        flg_d.invalid = snan_a | snan_b;
      end else if ((ca == cls_inf && cb == cls_inf) || (ca == cls_zero && cb == cls_zero)) begin
        cls_d = cls_nan;
        flg_d.invalid = 1'b1;
      end else if (ca == cls_inf) begin
        cls_d = cls_inf;
      end else if (cb == cls_zero) begin
        cls_d = cls_inf;
        flg_d.div_zero = 1'b1;
      end else if (ca == cls_zero || cb == cls_inf) begin
        cls_d = cls_zero;
      end
    end
  end

  // lowest idle engine wins
  assign job.start = {job_v & ~job.idle[0] & job.idle[1], job_v & job.idle[0]};
  assign busy = job_v & ~(|job.idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      job_v <= 1'b0;
    end else if (in_en) begin
      job_v <= 1'b1;
    end else if (|job.start) begin
      job_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_en) begin
      op_r <= in_op;
      sign_r <= sign_d;
      exp_r <= exp_d;
      ma_r <= ma_d;
      mb_r <= mb_d;
      cls_r <= cls_d;
      flg_r <= flg_d;
      tag_r <= in_tag;
    end
  end

  assign job.op = op_r;
  assign job.sign = sign_r;
  assign job.exp_q = exp_r;
  assign job.mant_a = ma_r;
  assign job.mant_b = mb_r;
  assign job.cls = cls_r;
  assign job.flags_pre = flg_r;
  assign job.tag = tag_r;

  a_no_req_busy: assert property (@(posedge clk) disable iff (rst) in_en |-> !busy);

endmodule

`default_nettype wire

// ==== design/rt_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module rt_engine #(
  parameter int TAG_W = 4,
  parameter int ENG_ID = 0
) (
  input  logic     clk,
  input  logic     rst,
  rt_job_if.engine job,
  rt_res_if.source res
);
  import rt_pkg::*;

  localparam int CNT_W = $clog2(ITER_STEPS + 1);
  localparam int REM_W = MANT_W + 6;
  localparam int RAD_W = 2 * ITER_STEPS;

  logic                  start_me;
  logic                  busy_q;
  logic                  done_q;
  logic [CNT_W-1:0]      cnt;

  logic [REM_W-1:0]      rem;
  logic [RAD_W-1:0]      rad;      // radicand, two bits per step
  logic [MANT_W-1:0]     dvs;
  logic [ITER_STEPS-1:0] quot;
  logic [REM_W-1:0]      step_in;
  logic [REM_W-1:0]      trial;
  logic [REM_W-1:0]      diff;
  logic [REM_W-1:0]      rem_nxt;
  logic                  q_bit;

  rt_op_e                op_q;
  logic                  sign_q;
  logic signed [9:0]     exp_q;
  rt_class_e             cls_q;
  fp_flags_s             flg_q;
  logic [TAG_W-1:0]      tag_q;

  assign start_me = job.start[ENG_ID];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt <= '0;
    end else if (start_me) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt <= CNT_W'(ITER_STEPS);
    end else if (res.take) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
      if (cnt == CNT_W'(1)) done_q <= 1'b1;   // last digit lands now
    end
  end

  // one restoring step, div or sqrt
  always_comb begin
    if (op_q == op_sqrt) begin
      step_in = {rem[REM_W-3:0], rad[RAD_W-1 -: 2]};
      trial = {{(REM_W - ITER_STEPS - 2){1'b0}}, quot, 2'b01};   // 4q+1
    end else begin
      step_in = rem;
      trial = {{(REM_W - MANT_W){1'b0}}, dvs};
    end
    q_bit = step_in >= trial;
    diff = q_bit ? step_in - trial : step_in;
    rem_nxt = (op_q == op_sqrt) ? diff : {diff[REM_W-2:0], 1'b0};
  end

  always_ff @(posedge clk) begin
    if (start_me) begin
      op_q <= job.op;
      sign_q <= job.sign;
      exp_q <= job.exp_q;
      cls_q <= job.cls;
      flg_q <= job.flags_pre;
      tag_q <= job.tag;
      dvs <= job.mant_b;
      quot <= '0;
      rad <= {job.mant_a, {(RAD_W - MANT_W - 1){1'b0}}};
      rem <= (job.op == op_sqrt) ? '0 : {{(REM_W - MANT_W - 1){1'b0}}, job.mant_a};
    end else if (cnt != '0) begin
      rem <= rem_nxt;
      rad <= {rad[RAD_W-3:0], 2'b00};
      quot <= {quot[ITER_STEPS-2:0], q_bit};
    end
  end

  assign job.idle[ENG_ID] = ~busy_q;

  assign res.done = done_q;
  assign res.sign = sign_q;
  assign res.exp_q = exp_q;
  assign res.quot = quot;
  assign res.sticky = |rem;   // anything left is below the last digit
  assign res.cls = cls_q;
  assign res.flags_pre = flg_q;
  assign res.tag = tag_q;

  a_start_idle: assert property (@(posedge clk) disable iff (rst) start_me |-> !busy_q);

endmodule

`default_nettype wire

// ==== design/rt_retire.sv ====
`timescale 1ns/1ps
`default_nettype none

module rt_retire #(
  parameter int TAG_W = 4
) (
  input  logic              clk,
  input  logic              rst,
  rt_res_if.sink            res0,
  rt_res_if.sink            res1,
  input  rt_pkg::fp_flags_s trap_en,
  output logic              out_en,
  output logic [31:0]       out_res,
  output rt_pkg::fp_flags_s out_flags,
  output logic [TAG_W-1:0]  out_tag,
  output logic              out_trap
);
  import rt_pkg::*;

  logic                  sel1;
  logic                  any_done;
  logic                  sign_s;
  logic signed [9:0]     exp_s;
  logic [ITER_STEPS-1:0] quot_s;
  logic                  stk_s;
  rt_class_e             cls_s;
  fp_flags_s             flg_s;
  logic [TAG_W-1:0]      tag_s;

  logic [MANT_W-1:0]     mant_n;
  logic                  guard;
  logic                  stk_n;
  logic signed [9:0]     exp_n;
  logic [MANT_W:0]       mant_r;
  logic signed [9:0]     exp_r;
  fp32_word_u            word_d;
  fp_flags_s             flags_d;

  // engine 0 first, engine 1 waits a cycle
  assign res0.take = res0.done;
  assign res1.take = res1.done & ~res0.done;
  assign sel1 = ~res0.done;
  assign any_done = res0.done | res1.done;

  assign sign_s = sel1 ? res1.sign : res0.sign;
  assign exp_s = sel1 ? res1.exp_q : res0.exp_q;
  assign quot_s = sel1 ? res1.quot : res0.quot;
  assign stk_s = sel1 ? res1.sticky : res0.sticky;
  assign cls_s = sel1 ? res1.cls : res0.cls;
  assign flg_s = sel1 ? res1.flags_pre : res0.flags_pre;
  assign tag_s = sel1 ? res1.tag : res0.tag;

  always_comb begin
    if (quot_s[ITER_STEPS-1]) begin
      mant_n = quot_s[ITER_STEPS-1 -: MANT_W];
      guard = quot_s[1];
      stk_n = quot_s[0] | stk_s;
      exp_n = exp_s;
    end else begin
      mant_n = quot_s[ITER_STEPS-2 -: MANT_W];  // quotient below 1
      guard = quot_s[0];
      stk_n = stk_s;
      exp_n = exp_s - 10'sd1;
    end
    // nearest even
    mant_r = {1'b0, mant_n} + (MANT_W + 1)'(guard & (stk_n | mant_n[0]));
    exp_r = exp_n + $signed({9'd0, mant_r[MANT_W]});
  end

  always_comb begin
    word_d.raw = QNAN_WORD;
    flags_d = flg_s;
    case (cls_s)
      cls_inf:  word_d.raw = {sign_s, 8'hff, 23'd0};
      cls_zero: word_d.raw = {sign_s, 31'd0};
      cls_num: begin
        word_d.f.sign = sign_s;
        flags_d.inexact = guard | stk_n;
        if (exp_r >= 10'sd255) begin
          word_d.f.exp = 8'hff;
          word_d.f.frac = '0;
          flags_d.overflow = 1'b1;
          flags_d.inexact = 1'b1;
        end else if (exp_r <= 10'sd0) begin
          word_d.f.exp = 8'h00;           // flush to signed zero
          word_d.f.frac = '0;
          flags_d.underflow = 1'b1;
          flags_d.inexact = 1'b1;
        end else begin
          word_d.f.exp = exp_r[7:0];
          word_d.f.frac = mant_r[22:0];   // zero when rounding carried out
        end
      end
      default: word_d.raw = QNAN_WORD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_en <= 1'b0;
    end else begin
      out_en <= any_done;
    end
  end

  always_ff @(posedge clk) begin
    out_res <= word_d.raw;
    out_flags <= flags_d;
    out_tag <= tag_s;
    out_trap <= |(flags_d & trap_en);
  end

  a_one_take: assert property (@(posedge clk) disable iff (rst) !(res0.take && res1.take));

endmodule

`default_nettype wire

// ==== design/fp_rt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_rt_unit #(
  parameter int TAG_W = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_en,
  input  rt_pkg::rt_op_e    in_op,
  input  logic [31:0]       in_a,
  input  logic [31:0]       in_b,
  input  logic [TAG_W-1:0]  in_tag,
  input  rt_pkg::fp_flags_s trap_en,
  output logic              busy,
  output logic              out_en,
  output logic [31:0]       out_res,
  output rt_pkg::fp_flags_s out_flags,
  output logic [TAG_W-1:0]  out_tag,
  output logic              out_trap
);

  rt_job_if #(.TAG_W(TAG_W)) job_bus ();
  rt_res_if #(.TAG_W(TAG_W)) res0_bus ();
  rt_res_if #(.TAG_W(TAG_W)) res1_bus ();

  rt_unpack #(.TAG_W(TAG_W)) u_unpack (
    .clk    (clk),
    .rst    (rst),
    .in_en  (in_en),
    .in_op  (in_op),
    .in_a   (in_a),
    .in_b   (in_b),
    .in_tag (in_tag),
    .busy   (busy),
    .job    (job_bus)
  );

  rt_engine #(.TAG_W(TAG_W), .ENG_ID(0)) eng0 (
    .clk (clk),
    .rst (rst),
    .job (job_bus),
    .res (res0_bus)
  );

  rt_engine #(.TAG_W(TAG_W), .ENG_ID(1)) eng1 (
    .clk (clk),
    .rst (rst),
    .job (job_bus),
    .res (res1_bus)
  );

  rt_retire #(.TAG_W(TAG_W)) u_retire (
    .clk       (clk),
    .rst       (rst),
    .res0      (res0_bus),
    .res1      (res1_bus),
    .trap_en   (trap_en),
    .out_en    (out_en),
    .out_res   (out_res),
    .out_flags (out_flags),
    .out_tag   (out_tag),
    .out_trap  (out_trap)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;   // released on an edge, like the stimulus
  end

endmodule

`default_nettype wire

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'hbde5_c427;

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// q has its binary point at bit 'point'; base_exp is the biased exponent for q in [1,2)
function automatic void round_pack(input logic sign, input logic [127:0] q, input int point,
                                   input logic rem_nz, input int base_exp,
                                   output fp32_word_u w, output fp_flags_s f);
  int          lead;
  int          sh;
  int          e;
  logic [24:0] m;
  logic        g;
  logic        s;
  lead = 0;
  for (int i = 0; i < 128; i++) begin
    if (q[i]) lead = i;
  end
  sh = lead - 23;
  m = 25'(q >> sh);
  g = q[sh-1];
  s = rem_nz || ((q & ((128'd1 << (sh - 1)) - 128'd1)) != 0);
  e = base_exp + lead - point;
  if (g && (s || m[0])) m = m + 25'd1;
  if (m[24]) begin
    m = m >> 1;   // carried into a new binade
    e = e + 1;
  end
  f = '0;
  w.raw = {sign, 31'd0};
  if (e >= 255) begin
    w.raw = {sign, 8'hff, 23'd0};
    f.overflow = 1'b1;
    f.inexact = 1'b1;
  end else if (e <= 0) begin
    f.underflow = 1'b1;   // flushed, sign kept
    f.inexact = 1'b1;
  end else begin
    w.raw = {sign, 8'(e), m[22:0]};
    f.inexact = g | s;
  end
endfunction

function automatic void ref_divsqrt(input rt_op_e op, input fp32_word_u a, input fp32_word_u b,
                                    output fp32_word_u w, output fp_flags_s f);
  logic         a_zero, a_inf, a_nan, a_snan;
  logic         b_zero, b_inf, b_nan, b_snan;
  logic         sign;
  logic [127:0] num;
  logic [127:0] q;
  logic [127:0] trial;
  int           ea;
  int           eb;
  a_zero = (a.f.exp == 8'h00);
  a_inf = (a.f.exp == 8'hff) && (a.f.frac == 0);
  a_nan = (a.f.exp == 8'hff) && (a.f.frac != 0);
  a_snan = a_nan && !a.f.frac[22];
  b_zero = (b.f.exp == 8'h00);
  b_inf = (b.f.exp == 8'hff) && (b.f.frac == 0);
  b_nan = (b.f.exp == 8'hff) && (b.f.frac != 0);
  b_snan = b_nan && !b.f.frac[22];
  ea = int'(a.f.exp) - EXP_BIAS;
  eb = int'(b.f.exp) - EXP_BIAS;
  f = '0;
  w.raw = QNAN_WORD;
  if (op == op_sqrt) begin
    if (a_nan) begin
      f.invalid = a_snan;
    end else if (a_zero) begin
      w.raw = {a.f.sign, 31'd0};
    end else if (a.f.sign) begin
      f.invalid = 1'b1;
    end else if (a_inf) begin
      w.raw = 32'h7f80_0000;
    end else begin
      num = 128'({1'b1, a.f.frac}) << 57;   // value times 2^80
      if (ea % 2 != 0) begin
        num = num << 1;
        ea = ea - 1;
      end
      q = '0;
      for (int i = 45; i >= 0; i--) begin
        trial = q | (128'd1 << i);
        if (trial * trial <= num) q = trial;
      end
      round_pack(1'b0, q, 40, (num - q * q) != 0, ea / 2 + EXP_BIAS, w, f);
    end
  end else begin
    sign = a.f.sign ^ b.f.sign;
    if (a_nan || b_nan) begin
      f.invalid = a_snan | b_snan;
    end else if ((a_inf && b_inf) || (a_zero && b_zero)) begin
      f.invalid = 1'b1;
    end else if (a_inf) begin
      w.raw = {sign, 8'hff, 23'd0};
    end else if (b_zero) begin
      w.raw = {sign, 8'hff, 23'd0};
      f.div_zero = 1'b1;
    end else if (a_zero || b_inf) begin
      w.raw = {sign, 31'd0};
    end else begin
      num = 128'({1'b1, a.f.frac}) << 50;
      q = num / 128'({1'b1, b.f.frac});
      round_pack(sign, q, 50, (num % 128'({1'b1, b.f.frac})) != 0, ea - eb + EXP_BIAS, w, f);
    end
  end
endfunction

task automatic check_word(input int tag, input fp32_word_u got, input fp32_word_u exp_w);
  if (got.raw !== exp_w.raw) begin
    $display("ERR %0t: tag %0d result %08h, expected %08h", $time, tag, got.raw, exp_w.raw);
    abort_run();
  end
endtask

task automatic check_flags(input int tag, input fp_flags_s got, input fp_flags_s exp_f);
  if (got !== exp_f) begin
    $display("ERR %0t: tag %0d flags %05b, expected %05b", $time, tag, got, exp_f);
    abort_run();
  end
endtask

task automatic check_trap(input int tag, input logic got, input logic exp_t);
  if (got !== exp_t) begin
    $display("ERR %0t: tag %0d trap %0b, expected %0b", $time, tag, got, exp_t);
    abort_run();
  end
endtask

`endif

// ==== sim/tb_fp_rt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fp_rt_unit;
  import rt_pkg::*;

  localparam int TAG_W = 4;
  localparam int NTAGS = 1 << TAG_W;
  localparam int CLK_NS = 40;
  localparam int WAIT_MAX = 200;   // cycles

  logic             clk;
  logic             rst;
  logic             in_en;
  rt_op_e           in_op;
  logic [31:0]      in_a;
  logic [31:0]      in_b;
  logic [TAG_W-1:0] in_tag;
  fp_flags_s        trap_en;
  logic             busy;
  logic             out_en;
  logic [31:0]      out_res;
  fp_flags_s        out_flags;
  logic [TAG_W-1:0] out_tag;
  logic             out_trap;

  // scoreboard, indexed by tag
  fp32_word_u exp_word [NTAGS];
  fp_flags_s  exp_flags [NTAGS];
  logic       exp_trap [NTAGS];
  logic       pend [NTAGS];
  logic       timed [NTAGS];
  longint     issue_t [NTAGS];
  int         pend_cnt;
  int         busy_seen;
  int         next_tag;
  fp_flags_s  trap_cur;

  tb_clk_gen #(.PERIOD(CLK_NS), .RST_CYCLES(3)) clk_gen (.clk(clk), .rst(rst));

  fp_rt_unit #(.TAG_W(TAG_W)) uut (
    .clk       (clk),
    .rst       (rst),
    .in_en     (in_en),
    .in_op     (in_op),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_tag    (in_tag),
    .trap_en   (trap_en),
    .busy      (busy),
    .out_en    (out_en),
    .out_res   (out_res),
    .out_flags (out_flags),
    .out_tag   (out_tag),
    .out_trap  (out_trap)
  );

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  `include "tb_ref_model.svh"

  function automatic logic [31:0] gen_operand();
    logic [2:0]  kind;
    logic        s;
    logic [7:0]  e;
    logic [22:0] fr;
    logic        pick;
    kind = 3'(rand_bits(3));
    s = (rand_bits(2) == 32'd0);   // mostly positive, keeps sqrt useful
    e = 8'(rand_bits(8));
    fr = 23'(rand_bits(23));
    pick = rand_bits(1) != 0;
    case (kind)
      3'd0: return {s, 8'h00, pick ? fr : 23'd0};        // zero or subnormal
      3'd1: return {s, 8'hff, pick ? (fr | 23'd1) : 23'd0};
      3'd2, 3'd3: return {s, 8'd100 + {2'b00, e[5:0]}, fr};
      default: return {s, (e == 8'h00 || e == 8'hff) ? 8'd127 : e, fr};
    endcase
  endfunction

  // one-cycle in_en pulse, so busy is valid before the next one
  task automatic issue(input rt_op_e op, input logic [31:0] a, input logic [31:0] b,
                       input logic lat_chk);
    fp32_word_u       wa;
    fp32_word_u       wb;
    fp32_word_u       w;
    fp_flags_s        f;
    logic [TAG_W-1:0] tag;
    int               n;
    n = 0;
    @(negedge clk);
    while (busy) begin
      if (n >= WAIT_MAX) begin
        $display("timeout while waiting for busy to drop");
        abort_run();
      end else begin
        n++;
        busy_seen++;
        @(negedge clk);
      end
    end
    tag = TAG_W'(next_tag);
    next_tag = (next_tag + 1) % NTAGS;
    wa.raw = a;
    wb.raw = b;
    ref_divsqrt(op, wa, wb, w, f);
    @(posedge clk);
    exp_word[tag] = w;
    exp_flags[tag] = f;
    exp_trap[tag] = |(5'(f) & 5'(trap_cur));
    pend[tag] = 1'b1;
    timed[tag] = lat_chk;
    issue_t[tag] = longint'($time);
    pend_cnt++;
    in_en <= 1'b1;
    in_op <= op;
    in_a <= a;
    in_b <= b;
    in_tag <= tag;
    @(posedge clk);
    in_en <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(posedge clk);
    while (pend_cnt != 0) begin
      if (n >= WAIT_MAX) begin
        $display("timeout with %0d results still missing", pend_cnt);
        abort_run();
      end else begin
        n++;
        @(posedge clk);
      end
    end
  endtask

  // only called with nothing in flight
  task automatic set_traps();
    @(posedge clk);
    trap_cur = fp_flags_s'(rand_bits(5));
    trap_en <= trap_cur;
  endtask

  task automatic run_one(input rt_op_e op, input logic [31:0] a, input logic [31:0] b);
    set_traps();
    issue(op, a, b, 1'b1);
    drain();
  endtask

  always @(negedge clk) begin
    fp32_word_u got;
    longint     lat;
    if (!rst && out_en) begin
      if (!pend[out_tag]) begin
        $display("a result came back with tag %0d, which is not outstanding", out_tag);
        abort_run();
      end else begin
        got.raw = out_res;
        check_word(int'(out_tag), got, exp_word[out_tag]);
        check_flags(int'(out_tag), out_flags, exp_flags[out_tag]);
        check_trap(int'(out_tag), out_trap, exp_trap[out_tag]);
        lat = (longint'($time) - issue_t[out_tag] - CLK_NS / 2) / CLK_NS;
        if (timed[out_tag] && lat != 29) begin
          $display("ERR %0t: tag %0d latency %0d cycles, expected 29", $time, out_tag, lat);
          abort_run();
        end
        pend[out_tag] = 1'b0;
        pend_cnt--;
      end
    end
  end

  initial begin
    int n;
    in_en = 1'b0;
    in_op = op_div;
    in_a = '0;
    in_b = '0;
    in_tag = '0;
    trap_en = '0;
    trap_cur = '0;
    pend_cnt = 0;
    busy_seen = 0;
    next_tag = 0;
    for (int i = 0; i < NTAGS; i++) begin
      pend[i] = 1'b0;
      timed[i] = 1'b0;
    end
    n = 0;
    @(posedge clk);
    while (rst !== 1'b0) begin
      if (n >= WAIT_MAX) begin
        $display("reset was never released");
        abort_run();
      end else begin
        n++;
        @(posedge clk);
      end
    end
    repeat (8) begin
      @(negedge clk);
      if (out_en !== 1'b0 || busy !== 1'b0) begin
        $display("ERR %0t: out_en %b busy %b after reset, expected both low", $time, out_en, busy);
        abort_run();
      end
    end

    // isolated normals
    run_one(op_div, 32'h3f80_0000, 32'h4040_0000);
    run_one(op_div, 32'h4049_0fdb, 32'h402d_f854);
    run_one(op_div, 32'h3f80_0000, 32'h3f80_0000);
    run_one(op_div, 32'hc0a0_0000, 32'h4000_0000);
    run_one(op_div, 32'h3fff_ffff, 32'h3f80_0001);
    run_one(op_sqrt, 32'h4000_0000, 32'h0);
    run_one(op_sqrt, 32'h4080_0000, 32'h0);
    run_one(op_sqrt, 32'h3f00_0000, 32'h0);   // odd exponent
    run_one(op_sqrt, 32'h4040_0000, 32'h0);
    run_one(op_sqrt, 32'h7f7f_ffff, 32'h0);

    // special operands
    run_one(op_div, 32'h0000_0000, 32'h0000_0000);
    run_one(op_div, 32'h7f80_0000, 32'hff80_0000);
    run_one(op_sqrt, 32'hc000_0000, 32'h0);
    run_one(op_div, 32'h3f80_0000, 32'h0000_0000);
    run_one(op_div, 32'hbf80_0000, 32'h0000_0000);
    run_one(op_sqrt, 32'h8000_0000, 32'h0);
    run_one(op_div, 32'h7f80_0000, 32'h4000_0000);
    run_one(op_div, 32'h4000_0000, 32'hff80_0000);
    run_one(op_div, 32'h0040_0000, 32'h4000_0000);
    run_one(op_div, 32'h4000_0000, 32'h8000_0001);
    run_one(op_sqrt, 32'h0000_0001, 32'h0);
    run_one(op_div, 32'h7fc0_0001, 32'h3f80_0000);
    run_one(op_div, 32'h7f80_0001, 32'h3f80_0000);
    run_one(op_sqrt, 32'h7fa0_0000, 32'h0);
    run_one(op_sqrt, 32'h7f80_0000, 32'h0);

    // range limits
    run_one(op_div, 32'h7f00_0000, 32'h0080_0000);
    run_one(op_div, 32'h7f7f_ffff, 32'h3f00_0000);
    run_one(op_div, 32'h0080_0000, 32'h7f00_0000);
    run_one(op_div, 32'h8080_0000, 32'h4000_0000);
    run_one(op_div, 32'h3f80_0000, 32'h7f7f_ffff);
    run_one(op_div, 32'h00ff_ffff, 32'h3f80_0000);

    // random bursts over both engines
    for (int batch = 0; batch < 24; batch++) begin
      set_traps();
      for (int k = 0; k < 6; k++) begin
        issue(rand_bits(1) != 0 ? op_sqrt : op_div, gen_operand(), gen_operand(), 1'b0);
      end
      drain();
    end

    if (busy_seen == 0) begin
      $display("busy never rose while both engines were occupied");
      abort_run();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== fp_rt_unit.f ====
+incdir+sim
design/rt_pkg.sv
design/rt_job_if.sv
design/rt_res_if.sv
design/rt_unpack.sv
design/rt_engine.sv
design/rt_retire.sv
design/fp_rt_unit.sv
sim/tb_clk_gen.sv
sim/tb_fp_rt_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the fp_rt_unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fp_rt_unit \
  -f fp_rt_unit.f \
  --Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
